// File: afu_pkg.sv
/*
  Common definitions for the AFU MMIO block and the units it reports on.
  Holds the register word map, the fixed AFU descriptor, the response
  event codes and the shared word widths. Modules pull it in with a
  wildcard import in their body and use scoped names in their ports.
*/
package afu_pkg;

  localparam int mmio_addr_width = 24;
  localparam int data_width      = 64;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  // Word addresses, always even since bit 0 picks the 32-bit half
  localparam logic [mmio_addr_width-1:0] cu_configure_addr       = 24'h00_0010;
  localparam logic [mmio_addr_width-1:0] cu_configure_2_addr     = 24'h00_0012;
  localparam logic [mmio_addr_width-1:0] cu_return_addr          = 24'h00_0014;
  localparam logic [mmio_addr_width-1:0] cu_return_2_addr        = 24'h00_0016;
  // Bit 0 is the done flag
  localparam logic [mmio_addr_width-1:0] cu_return_done_addr     = 24'h00_0018;
  localparam logic [mmio_addr_width-1:0] cu_return_done_ack_addr = 24'h00_001A;
  localparam logic [mmio_addr_width-1:0] error_reg_addr          = 24'h00_001C;
  localparam logic [mmio_addr_width-1:0] error_reg_ack_addr      = 24'h00_001E;
  // Bit 0 busy, bit 1 done
  localparam logic [mmio_addr_width-1:0] cu_status_addr          = 24'h00_0020;
  localparam logic [mmio_addr_width-1:0] done_read_count_addr    = 24'h00_0022;
  localparam logic [mmio_addr_width-1:0] done_write_count_addr   = 24'h00_0024;
  localparam logic [mmio_addr_width-1:0] read_byte_count_addr    = 24'h00_0026;
  localparam logic [mmio_addr_width-1:0] write_byte_count_addr   = 24'h00_0028;

  //////////////////////////////////////////////////
  // AFU descriptor, read through config space
  //////////////////////////////////////////////////

  localparam int descriptor_words       = 4;
  localparam int descriptor_index_width = $clog2(descriptor_words);

  localparam logic [data_width-1:0] afu_descriptor [descriptor_words] = '{
    // No interrupts, one process, one config record, dedicated process model
    64'h0000_0001_0001_8010,
    // Config record length
    64'h0000_0000_0000_0001,
    // Config record offset
    64'h0000_0000_0000_0100,
    // PSA required, zero PSA length
    64'h0100_0000_0000_0000
  };

  // Response events from the compute unit
  localparam int resp_code_width = 2;
  typedef logic [resp_code_width-1:0] resp_code_t;
  localparam resp_code_t resp_done_read  = 2'd1;
  localparam resp_code_t resp_done_write = 2'd2;

  // Bytes credited per response
  localparam int resp_bytes = 64;

  // Sticky error register layout
  localparam int error_width     = 64;
  localparam int err_addr_parity = 0;
  localparam int err_data_parity = 1;

endpackage

// File: mmio.sv
/*
  Host MMIO pipeline. Takes single-word host reads and writes, checks odd
  parity on address and write data, serves the AFU descriptor in config
  space and decodes the register map. Every request is acked exactly five
  cycles after its valid pulse, with read data and odd parity alongside.
*/
`timescale 1ns/1ns

module mmio (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                mmio_valid,
  input  logic                                mmio_cfg,
  input  logic                                mmio_read,
  input  logic                                mmio_doubleword,
  input  logic [afu_pkg::mmio_addr_width-1:0] mmio_address,
  input  logic                                mmio_address_parity,
  input  logic [afu_pkg::data_width-1:0]      mmio_data,
  input  logic                                mmio_data_parity,
  input  logic [afu_pkg::data_width-1:0]      cu_sum,
  input  logic [afu_pkg::data_width-1:0]      cu_steps,
  input  logic                                cu_done,
  input  logic                                cu_busy,
  input  logic [afu_pkg::data_width-1:0]      done_read_count,
  input  logic [afu_pkg::data_width-1:0]      done_write_count,
  input  logic [afu_pkg::data_width-1:0]      read_byte_count,
  input  logic [afu_pkg::data_width-1:0]      write_byte_count,
  input  logic [afu_pkg::error_width-1:0]     report_errors,
  output logic                                mmio_ack,
  output logic [afu_pkg::data_width-1:0]      mmio_rdata,
  output logic                                mmio_rdata_parity,
  output logic [1:0]                          mmio_errors,
  output logic                                cu_config_count_valid,
  output logic                                cu_config_start_valid,
  output logic [afu_pkg::data_width-1:0]      cu_config_data,
  output logic                                cu_done_clear,
  output logic                                error_clear_valid,
  output logic [afu_pkg::error_width-1:0]     error_clear_mask
);
  import afu_pkg::*;

  // Input stage
  logic                       valid_s1;
  logic                       cfg_s1;
  logic                       read_s1;
  logic                       dw_s1;
  logic [mmio_addr_width-1:0] addr_s1;
  logic                       addr_par_s1;
  logic [data_width-1:0]      data_s1;
  logic                       data_par_s1;

  // Decode and decode delay stages
  logic                       cfg_read_s2;
  logic                       cfg_write_s2;
  logic                       reg_read_s2;
  logic                       reg_write_s2;
  logic                       cfg_read_s3;
  logic                       cfg_write_s3;
  logic                       reg_read_s3;
  logic                       reg_write_s3;
  logic                       dw_s2;
  logic                       dw_s3;
  logic [mmio_addr_width-1:0] addr_s2;
  logic [mmio_addr_width-1:0] addr_s3;
  logic [data_width-1:0]      data_s2;
  logic [data_width-1:0]      data_s3;
  logic [data_width-1:0]      cfg_data_s3;
  logic [1:0]                 err_s2;
  logic [1:0]                 err_s3;

  // Data select stage
  logic                       ack_s4;
  logic [1:0]                 err_s4;
  logic [data_width-1:0]      data_out;

  // Register sources sampled once a cycle
  logic [data_width-1:0]      sum_q;
  logic [data_width-1:0]      steps_q;
  logic [data_width-1:0]      done_q;
  logic [data_width-1:0]      status_q;
  logic [data_width-1:0]      errors_q;
  logic [data_width-1:0]      rd_count_q;
  logic [data_width-1:0]      wr_count_q;
  logic [data_width-1:0]      rd_bytes_q;
  logic [data_width-1:0]      wr_bytes_q;

  always_ff @(posedge clock) begin
    sum_q      <= cu_sum;
    steps_q    <= cu_steps;
    done_q     <= {{(data_width-1){1'b0}}, cu_done};
    status_q   <= {{(data_width-2){1'b0}}, cu_done, cu_busy};
    errors_q   <= report_errors;
    rd_count_q <= done_read_count;
    wr_count_q <= done_write_count;
    rd_bytes_q <= read_byte_count;
    wr_bytes_q <= write_byte_count;
  end

  //////////////////////////////////////////////////
  // Request pipeline
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    cfg_s1      <= mmio_cfg;
    read_s1     <= mmio_read;
    dw_s1       <= mmio_doubleword;
    addr_s1     <= mmio_address;
    addr_par_s1 <= mmio_address_parity;
    data_s1     <= mmio_data;
    data_par_s1 <= mmio_data_parity;
    dw_s2       <= dw_s1;
    addr_s2     <= addr_s1;
    data_s2     <= data_s1;
    dw_s3       <= dw_s2;
    addr_s3     <= addr_s2;
    data_s3     <= data_s2;
    // Descriptor word by doubleword index, zero past the end
    if (addr_s2[mmio_addr_width-1:1] < descriptor_words) begin
      cfg_data_s3 <= afu_descriptor[addr_s2[descriptor_index_width:1]];
    end else begin
      cfg_data_s3 <= '0;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      valid_s1     <= 1'b0;
      cfg_read_s2  <= 1'b0;
      cfg_write_s2 <= 1'b0;
      reg_read_s2  <= 1'b0;
      reg_write_s2 <= 1'b0;
      err_s2       <= 2'b00;
      cfg_read_s3  <= 1'b0;
      cfg_write_s3 <= 1'b0;
      reg_read_s3  <= 1'b0;
      reg_write_s3 <= 1'b0;
      err_s3       <= 2'b00;
    end else begin
      valid_s1     <= mmio_valid;
      cfg_read_s2  <= valid_s1 &&  cfg_s1 &&  read_s1;
      cfg_write_s2 <= valid_s1 &&  cfg_s1 && !read_s1;
      reg_read_s2  <= valid_s1 && !cfg_s1 &&  read_s1;
      reg_write_s2 <= valid_s1 && !cfg_s1 && !read_s1;
      // Odd parity, so the XOR over value and parity bit must be 1
      err_s2[0]    <= valid_s1 && !(^{addr_s1, addr_par_s1});
      err_s2[1]    <= valid_s1 && !read_s1 && !(^{data_s1, data_par_s1});
      cfg_read_s3  <= cfg_read_s2;
      cfg_write_s3 <= cfg_write_s2;
      reg_read_s3  <= reg_read_s2;
      reg_write_s3 <= reg_write_s2;
      err_s3       <= err_s2;
    end
  end

  //////////////////////////////////////////////////
  // Write decode and read data select
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    cu_config_data   <= data_s3;
    error_clear_mask <= data_s3;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ack_s4                <= 1'b0;
      err_s4                <= 2'b00;
      data_out              <= '0;
      cu_config_count_valid <= 1'b0;
      cu_config_start_valid <= 1'b0;
      cu_done_clear         <= 1'b0;
      error_clear_valid     <= 1'b0;
    end else begin
      ack_s4 <= cfg_read_s3 || cfg_write_s3 || reg_read_s3 || reg_write_s3;
      err_s4 <= err_s3;
      cu_config_count_valid <= reg_write_s3 && (addr_s3 == cu_configure_addr);
      cu_config_start_valid <= reg_write_s3 && (addr_s3 == cu_configure_2_addr);
      cu_done_clear     <= reg_write_s3 && (addr_s3 == cu_return_done_ack_addr) && data_s3[0];
      error_clear_valid <= reg_write_s3 && (addr_s3 == error_reg_ack_addr);
      if (cfg_read_s3) begin
        // Single words repeat the chosen half, bit 0 low picks the upper one
        if (dw_s3) begin
          data_out <= cfg_data_s3;
        end else if (addr_s3[0]) begin
          data_out <= {2{cfg_data_s3[data_width/2-1:0]}};
        end else begin
          data_out <= {2{cfg_data_s3[data_width-1:data_width/2]}};
        end
      end else if (reg_read_s3) begin
        case (addr_s3)
          cu_return_addr:        data_out <= sum_q;
          cu_return_2_addr:      data_out <= steps_q;
          cu_return_done_addr:   data_out <= done_q;
          cu_status_addr:        data_out <= status_q;
          error_reg_addr:        data_out <= errors_q;
          done_read_count_addr:  data_out <= rd_count_q;
          done_write_count_addr: data_out <= wr_count_q;
          read_byte_count_addr:  data_out <= rd_bytes_q;
          write_byte_count_addr: data_out <= wr_bytes_q;
          // Unmapped reads hold the last value
          default:               data_out <= data_out;
        endcase
      end
    end
  end

  // Output register toward the host
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_ack          <= 1'b0;
      mmio_rdata        <= '0;
      mmio_rdata_parity <= 1'b1;
      mmio_errors       <= 2'b00;
    end else begin
      mmio_ack          <= ack_s4;
      mmio_rdata        <= data_out;
      mmio_rdata_parity <= ~(^data_out);
      mmio_errors       <= err_s4;
    end
  end

endmodule

// File: cu_sum_engine.sv
/*
  Compute unit used as the MMIO target. A count write sets the number of
  steps, a seed write starts a run that adds the seed once per cycle.
  Each step emits one response event, alternating read and write.
*/
`timescale 1ns/1ns

module cu_sum_engine #(
  parameter int step_count_width = 32
) (
  input  logic                           clock,
  input  logic                           rstn,
  input  logic                           config_count_valid,
  input  logic                           config_start_valid,
  input  logic [afu_pkg::data_width-1:0] config_data,
  input  logic                           done_clear,
  output logic [afu_pkg::data_width-1:0] sum,
  output logic [afu_pkg::data_width-1:0] steps,
  output logic                           done,
  output logic                           busy,
  output logic                           resp_valid,
  output afu_pkg::resp_code_t            resp_code
);
  import afu_pkg::*;

  logic [step_count_width-1:0] step_count;
  logic [step_count_width-1:0] remaining;
  logic [data_width-1:0]       seed;

  always_ff @(posedge clock) begin
    if (config_start_valid && !busy) begin
      seed <= config_data;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      step_count <= '0;
      remaining  <= '0;
      sum        <= '0;
      steps      <= '0;
      done       <= 1'b0;
      busy       <= 1'b0;
      resp_valid <= 1'b0;
      resp_code  <= '0;
    end else begin
      resp_valid <= 1'b0;
      if (config_count_valid) begin
        step_count <= config_data[step_count_width-1:0];
      end
      if (done_clear) begin
        done <= 1'b0;
      end
      if (busy) begin
        if (remaining == '0) begin
          // Zero-step run ends after its one busy cycle
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          sum        <= sum + seed;
          steps      <= steps + 1'b1;
          remaining  <= remaining - 1'b1;
          resp_valid <= 1'b1;
          // Even step index reads, odd index writes
          resp_code  <= steps[0] ? resp_done_write : resp_done_read;
          if (remaining == 1) begin
            busy <= 1'b0;
            done <= 1'b1;
          end
        end
      end else if (config_start_valid) begin
        sum       <= '0;
        steps     <= '0;
        remaining <= step_count;
        busy      <= 1'b1;
        done      <= 1'b0;
      end
    end
  end

endmodule

// File: response_counters.sv
/*
  Response statistics. Counts read and write response events from the
  compute unit and the bytes they stand for. Counters wrap and clear
  only on reset.
*/
`timescale 1ns/1ns

module response_counters #(
  parameter int counter_width = 64
) (
  input  logic                     clock,
  input  logic                     rstn,
  input  logic                     resp_valid,
  input  afu_pkg::resp_code_t      resp_code,
  output logic [counter_width-1:0] done_read_count,
  output logic [counter_width-1:0] done_write_count,
  output logic [counter_width-1:0] read_byte_count,
  output logic [counter_width-1:0] write_byte_count
);
  import afu_pkg::*;

  localparam logic [counter_width-1:0] bytes_per_resp = counter_width'(resp_bytes);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      done_read_count  <= '0;
      done_write_count <= '0;
      read_byte_count  <= '0;
      write_byte_count <= '0;
    end else if (resp_valid) begin
      case (resp_code)
        resp_done_read: begin
          done_read_count <= done_read_count + 1'b1;
          read_byte_count <= read_byte_count + bytes_per_resp;
        end
        resp_done_write: begin
          done_write_count <= done_write_count + 1'b1;
          write_byte_count <= write_byte_count + bytes_per_resp;
        end
        default: begin
          // Other codes are not tallied
        end
      endcase
    end
  end

endmodule

// File: error_collector.sv
/*
  Sticky error register behind ERROR_REG. Parity errors seen on host
  requests are ORed in, and a write to ERROR_REG_ACK clears the bits of
  its mask. A new error wins over a clear in the same cycle.
*/
`timescale 1ns/1ns

module error_collector (
  input  logic                            clock,
  input  logic                            rstn,
  input  logic [1:0]                      mmio_errors,
  input  logic                            error_clear_valid,
  input  logic [afu_pkg::error_width-1:0] error_clear_mask,
  output logic [afu_pkg::error_width-1:0] report_errors
);
  import afu_pkg::*;

  logic [error_width-1:0] set_bits;
  logic [error_width-1:0] clear_bits;

  // Map the request error pair onto register bit positions
  always_comb begin
    set_bits                  = '0;
    set_bits[err_addr_parity] = mmio_errors[0];
    set_bits[err_data_parity] = mmio_errors[1];
    clear_bits = error_clear_valid ? error_clear_mask : '0;
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      report_errors <= '0;
    end else begin
      report_errors <= (report_errors & ~clear_bits) | set_bits;
    end
  end

endmodule

// File: afu_top.sv
/*
  AFU top level. Connects the host MMIO port to the MMIO pipeline and
  hangs the compute unit, response counters and error register off it.
*/
`timescale 1ns/1ns

module afu_top #(
  parameter int step_count_width = 32,
  parameter int counter_width    = 64
) (
  input  logic                                clock,
  input  logic                                rstn,
  input  logic                                mmio_valid,
  input  logic                                mmio_cfg,
  input  logic                                mmio_read,
  input  logic                                mmio_doubleword,
  input  logic [afu_pkg::mmio_addr_width-1:0] mmio_address,
  input  logic                                mmio_address_parity,
  input  logic [afu_pkg::data_width-1:0]      mmio_data,
  input  logic                                mmio_data_parity,
  output logic                                mmio_ack,
  output logic [afu_pkg::data_width-1:0]      mmio_rdata,
  output logic                                mmio_rdata_parity,
  output logic [1:0]                          mmio_errors
);
  import afu_pkg::*;

  logic                     cu_config_count_valid;
  logic                     cu_config_start_valid;
  logic [data_width-1:0]    cu_config_data;
  logic                     cu_done_clear;
  logic [data_width-1:0]    cu_sum;
  logic [data_width-1:0]    cu_steps;
  logic                     cu_done;
  logic                     cu_busy;
  logic                     resp_valid;
  resp_code_t               resp_code;
  logic [counter_width-1:0] done_read_count;
  logic [counter_width-1:0] done_write_count;
  logic [counter_width-1:0] read_byte_count;
  logic [counter_width-1:0] write_byte_count;
  logic                     error_clear_valid;
  logic [error_width-1:0]   error_clear_mask;
  logic [error_width-1:0]   report_errors;

  mmio u_mmio (
    .clock                 (clock),
    .rstn                  (rstn),
    .mmio_valid            (mmio_valid),
    .mmio_cfg              (mmio_cfg),
    .mmio_read             (mmio_read),
    .mmio_doubleword       (mmio_doubleword),
    .mmio_address          (mmio_address),
    .mmio_address_parity   (mmio_address_parity),
    .mmio_data             (mmio_data),
    .mmio_data_parity      (mmio_data_parity),
    .cu_sum                (cu_sum),
    .cu_steps              (cu_steps),
    .cu_done               (cu_done),
    .cu_busy               (cu_busy),
    .done_read_count       (done_read_count),
    .done_write_count      (done_write_count),
    .read_byte_count       (read_byte_count),
    .write_byte_count      (write_byte_count),
    .report_errors         (report_errors),
    .mmio_ack              (mmio_ack),
    .mmio_rdata            (mmio_rdata),
    .mmio_rdata_parity     (mmio_rdata_parity),
    .mmio_errors           (mmio_errors),
    .cu_config_count_valid (cu_config_count_valid),
    .cu_config_start_valid (cu_config_start_valid),
    .cu_config_data        (cu_config_data),
    .cu_done_clear         (cu_done_clear),
    .error_clear_valid     (error_clear_valid),
    .error_clear_mask      (error_clear_mask)
  );

  cu_sum_engine #(
    .step_count_width (step_count_width)
  ) u_cu_sum_engine (
    .clock              (clock),
    .rstn               (rstn),
    .config_count_valid (cu_config_count_valid),
    .config_start_valid (cu_config_start_valid),
    .config_data        (cu_config_data),
    .done_clear         (cu_done_clear),
    .sum                (cu_sum),
    .steps              (cu_steps),
    .done               (cu_done),
    .busy               (cu_busy),
    .resp_valid         (resp_valid),
    .resp_code          (resp_code)
  );

  response_counters #(
    .counter_width (counter_width)
  ) u_response_counters (
    .clock            (clock),
    .rstn             (rstn),
    .resp_valid       (resp_valid),
    .resp_code        (resp_code),
    .done_read_count  (done_read_count),
    .done_write_count (done_write_count),
    .read_byte_count  (read_byte_count),
    .write_byte_count (write_byte_count)
  );

  error_collector u_error_collector (
    .clock             (clock),
    .rstn              (rstn),
    .mmio_errors       (mmio_errors),
    .error_clear_valid (error_clear_valid),
    .error_clear_mask  (error_clear_mask),
    .report_errors     (report_errors)
  );

endmodule

// File: tb_mmio_tasks.svh
/*
  Host-side MMIO tasks for the AFU testbench, included in the testbench
  module. They drive one request with odd parity (or a deliberately broken
  one) on the falling edge, wait for the ack and keep the model's last read
  data and sticky error bits up to date.
*/

// Compare a value with its expectation, report a mismatch
task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
  if (actual !== expected) begin
    error_count++;
    $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
  end
endtask

// One host request, ack expected exactly five cycles later
task automatic host_access(input logic is_cfg, input logic is_read, input logic is_dw,
                           input logic [23:0] addr, input logic [63:0] wdata,
                           input logic bad_addr_par, input logic bad_data_par,
                           output logic [63:0] rdata);
  int         cycles;
  logic       acked;
  logic [1:0] exp_errors;
  // Data parity only counts on writes
  exp_errors          = {!is_read && bad_data_par, bad_addr_par};
  @(negedge clock);
  mmio_valid          = 1'b1;
  mmio_cfg            = is_cfg;
  mmio_read           = is_read;
  mmio_doubleword     = is_dw;
  mmio_address        = addr;
  mmio_address_parity = ~(^addr) ^ bad_addr_par;
  mmio_data           = wdata;
  mmio_data_parity    = ~(^wdata) ^ bad_data_par;
  cycles = 0;
  acked  = 1'b0;
  rdata  = '0;
  while (!acked && cycles < ack_timeout) begin
    @(negedge clock);
    mmio_valid = 1'b0;
    cycles++;
    acked = mmio_ack;
  end
  if (!acked) begin
    timeout_count++;
    $display("Timeout at %0t ns: no mmio_ack within %0d cycles for address %h",
             $time, ack_timeout, addr);
  end else begin
    check_value("mmio_ack latency", 64'(cycles), 64'd5);
    check_value("mmio_errors", 64'(mmio_errors), 64'(exp_errors));
    check_value("mmio_rdata_parity", 64'(^{mmio_rdata, mmio_rdata_parity}), 64'd1);
    rdata = mmio_rdata;
    if (!is_read) begin
      check_value("mmio_rdata on write", mmio_rdata, last_rdata);
    end
  end
  sticky_errors = sticky_errors | {62'b0, exp_errors};
endtask

task automatic write_register(input logic [23:0] addr, input logic [63:0] wdata);
  logic [63:0] rdata;
  host_access(1'b0, 1'b0, 1'b0, addr, wdata, 1'b0, 1'b0, rdata);
endtask

// Read with clean parity and check against the model
task automatic read_expect(input logic is_cfg, input logic is_dw, input logic [23:0] addr,
                           input logic [63:0] expected, input string name);
  logic [63:0] rdata;
  host_access(is_cfg, 1'b1, is_dw, addr, 64'h0, 1'b0, 1'b0, rdata);
  check_value(name, rdata, expected);
  last_rdata = expected;
endtask

// File: tb_afu_top.sv
/*
  Testbench for the AFU top level. Runs config-space reads, random compute
  runs with statistics checks, parity error injection with sticky error
  clearing, and unmapped reads, all against a model kept here.
*/
`timescale 1ns/1ns

module tb_afu_top;
  import afu_pkg::*;

  localparam int ack_timeout     = 20;
  localparam int poll_limit      = 100;
  localparam int run_count       = 12;
  localparam int parity_trials   = 24;
  localparam int bytes_per_event = 64;

  logic        clock;
  logic        rstn;
  logic        mmio_valid;
  logic        mmio_cfg;
  logic        mmio_read;
  logic        mmio_doubleword;
  logic [23:0] mmio_address;
  logic        mmio_address_parity;
  logic [63:0] mmio_data;
  logic        mmio_data_parity;
  logic        mmio_ack;
  logic [63:0] mmio_rdata;
  logic        mmio_rdata_parity;
  logic [1:0]  mmio_errors;

  integer      seed;
  int          error_count;
  int          timeout_count;
  // Model state
  logic [63:0] descriptor [4];
  logic [63:0] last_rdata;
  logic [63:0] sticky_errors;
  logic [63:0] exp_read_events;
  logic [63:0] exp_write_events;

  afu_top #(
    .step_count_width (32),
    .counter_width    (64)
  ) dut (
    .clock               (clock),
    .rstn                (rstn),
    .mmio_valid          (mmio_valid),
    .mmio_cfg            (mmio_cfg),
    .mmio_read           (mmio_read),
    .mmio_doubleword     (mmio_doubleword),
    .mmio_address        (mmio_address),
    .mmio_address_parity (mmio_address_parity),
    .mmio_data           (mmio_data),
    .mmio_data_parity    (mmio_data_parity),
    .mmio_ack            (mmio_ack),
    .mmio_rdata          (mmio_rdata),
    .mmio_rdata_parity   (mmio_rdata_parity),
    .mmio_errors         (mmio_errors)
  );

  `include "tb_mmio_tasks.svh"

  always #5 clock = ~clock;

  //////////////////////////////////////////////////
  // Scenarios
  //////////////////////////////////////////////////

  task automatic check_config_space();
    int          i;
    logic [63:0] rdata;
    for (i = 0; i < 4; i++) begin
      read_expect(1'b1, 1'b1, 24'(i * 2), descriptor[i], "mmio_rdata (config dw)");
      read_expect(1'b1, 1'b0, 24'(i * 2), {2{descriptor[i][63:32]}}, "mmio_rdata (config upper)");
      read_expect(1'b1, 1'b0, 24'(i * 2 + 1), {2{descriptor[i][31:0]}}, "mmio_rdata (config lower)");
    end
    // Config writes are acked and leave the read data alone
    host_access(1'b1, 1'b0, 1'b1, 24'h0, {$random(seed), $random(seed)}, 1'b0, 1'b0, rdata);
  endtask

  task automatic run_compute(input int count, input logic [63:0] seed_value);
    logic [63:0] rdata;
    logic [63:0] exp_status;
    logic        busy;
    int          polls;
    write_register(cu_configure_addr, 64'(count));
    write_register(cu_configure_2_addr, seed_value);
    polls = 0;
    busy  = 1'b1;
    while (busy && polls < poll_limit) begin
      host_access(1'b0, 1'b1, 1'b0, cu_status_addr, 64'h0, 1'b0, 1'b0, rdata);
      polls++;
      busy = rdata[0];
      // Running shows busy only, finished shows done only
      exp_status = busy ? 64'h1 : 64'h2;
      check_value("mmio_rdata (CU_STATUS)", rdata, exp_status);
      last_rdata = exp_status;
    end
    if (busy) begin
      timeout_count++;
      $display("Timeout at %0t ns: compute unit still busy after %0d status reads", $time, polls);
    end
    read_expect(1'b0, 1'b0, cu_return_addr, seed_value * 64'(count), "mmio_rdata (CU_RETURN)");
    read_expect(1'b0, 1'b0, cu_return_2_addr, 64'(count), "mmio_rdata (CU_RETURN_2)");
    read_expect(1'b0, 1'b0, cu_return_done_addr, 64'h1, "mmio_rdata (CU_RETURN_DONE)");
    write_register(cu_return_done_ack_addr, 64'h1);
    read_expect(1'b0, 1'b0, cu_return_done_addr, 64'h0, "mmio_rdata (CU_RETURN_DONE acked)");
    // Even steps read, odd steps write
    exp_read_events  = exp_read_events + 64'((count + 1) / 2);
    exp_write_events = exp_write_events + 64'(count / 2);
    read_expect(1'b0, 1'b0, done_read_count_addr, exp_read_events, "mmio_rdata (DONE_READ)");
    read_expect(1'b0, 1'b0, done_write_count_addr, exp_write_events, "mmio_rdata (DONE_WRITE)");
    read_expect(1'b0, 1'b0, read_byte_count_addr, exp_read_events * bytes_per_event,
                "mmio_rdata (READ_BYTES)");
    read_expect(1'b0, 1'b0, write_byte_count_addr, exp_write_events * bytes_per_event,
                "mmio_rdata (WRITE_BYTES)");
  endtask

  task automatic check_parity_errors();
    int          i;
    logic [63:0] rdata;
    logic [63:0] mask;
    logic [23:0] addr;
    logic [2:0]  pick;
    for (i = 0; i < parity_trials; i++) begin
      // Unmapped targets, so broken writes change nothing
      addr = 24'h80_0000 | {8'h00, 16'($random(seed))};
      pick = 3'($random(seed));
      host_access(1'b0, pick[0], 1'b0, addr, {$random(seed), $random(seed)},
                  pick[1], pick[2], rdata);
      if (pick[0]) begin
        check_value("mmio_rdata (unmapped, bad parity)", rdata, last_rdata);
      end
      if (i % 6 == 5) begin
        read_expect(1'b0, 1'b0, error_reg_addr, sticky_errors, "mmio_rdata (ERROR_REG)");
        mask = {$random(seed), $random(seed)};
        write_register(error_reg_ack_addr, mask);
        sticky_errors = sticky_errors & ~mask;
        read_expect(1'b0, 1'b0, error_reg_addr, sticky_errors, "mmio_rdata (ERROR_REG cleared)");
      end
    end
  endtask

  task automatic check_unmapped_read();
    read_expect(1'b0, 1'b0, done_read_count_addr, exp_read_events, "mmio_rdata (DONE_READ)");
    read_expect(1'b0, 1'b0, 24'h00_0030, last_rdata, "mmio_rdata (unmapped 0x30)");
    read_expect(1'b0, 1'b0, 24'h00_0011, last_rdata, "mmio_rdata (unmapped 0x11)");
    read_expect(1'b0, 1'b0, 24'hFF_FFFE, last_rdata, "mmio_rdata (unmapped 0xfffffe)");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int r;
    seed                = 66179;
    error_count         = 0;
    timeout_count       = 0;
    clock               = 1'b0;
    rstn                = 1'b0;
    mmio_valid          = 1'b0;
    mmio_cfg            = 1'b0;
    mmio_read           = 1'b0;
    mmio_doubleword     = 1'b0;
    mmio_address        = '0;
    mmio_address_parity = 1'b1;
    mmio_data           = '0;
    mmio_data_parity    = 1'b1;
    // Interrupts/processes/record/model, record length, record offset, PSA
    descriptor[0]       = 64'h0000_0001_0001_8010;
    descriptor[1]       = 64'h0000_0000_0000_0001;
    descriptor[2]       = 64'h0000_0000_0000_0100;
    descriptor[3]       = 64'h0100_0000_0000_0000;
    last_rdata          = '0;
    sticky_errors       = '0;
    exp_read_events     = '0;
    exp_write_events    = '0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;
    @(negedge clock);
    check_value("mmio_ack after reset", 64'(mmio_ack), 64'h0);
    check_value("mmio_errors after reset", 64'(mmio_errors), 64'h0);

    check_config_space();
    run_compute(0, {$random(seed), $random(seed)});
    run_compute(40, {$random(seed), $random(seed)});
    for (r = 0; r < run_count; r++) begin
      run_compute(int'($unsigned($random(seed)) % 41), {$random(seed), $random(seed)});
    end
    check_parity_errors();
    check_unmapped_read();

    $display("Closing report: %0d check errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: afu_top.f
+incdir+.
afu_pkg.sv
mmio.sv
cu_sum_engine.sv
response_counters.sv
error_collector.sv
afu_top.sv
tb_afu_top.sv

// File: run.sh
#!/bin/sh
# Build the AFU testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f afu_top.f --top-module tb_afu_top -o sim_afu
out=$(./obj_dir/sim_afu)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q -F '*** PASSED ***'; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
